// File: project.f
+incdir+include
logic/serial_rf_pkg.sv
logic/rf_port_map.sv
logic/rf_serializer.sv
logic/rf_ram.sv
logic/serial_rf_top.sv
tests/tb_serial_rf.sv

// File: tests/tb_serial_rf.sv
`timescale 1ns/10ps
`include "serial_rf_config.svh"
`default_nettype none

module tb_serial_rf;

   localparam int ACK_TIMEOUT    = 20;
   localparam int STREAM_TIMEOUT = 80;

   logic       clk;
   logic       rst_n;
   logic       req;
   logic       trap;
   logic       mret;
   logic       mepc;
   logic       mem_misalign;
   logic       bufreg_q;
   logic       bad_pc;
   logic       csr_en;
   logic       csr;
   logic [1:0] csr_addr;
   logic       rd_wen;
   logic       ctrl_rd;
   logic       alu_rd;
   logic       rd_alu_en;
   logic       csr_rd;
   logic       rd_csr_en;
   logic       mem_rd;
   logic [4:0] rd_waddr;
   logic [4:0] rs1_raddr;
   logic [4:0] rs2_raddr;
   wire        ack;
   wire        csr_pc;
   wire        csr_out;
   wire        rs1;
   wire        rs2;

   // Register file model with 32 integer registers and 4 CSRs
   logic [31:0] model_x [32];
   logic [31:0] model_csr [4];
   // Bit streams of the current request
   logic [31:0] v_ctrl;
   logic [31:0] v_alu;
   logic [31:0] v_csr_rd;
   logic [31:0] v_mem;
   logic [31:0] v_csr;
   logic [31:0] v_mepc;
   logic [31:0] v_bufreg;
   logic [31:0] v_bad_pc;
   logic [31:0] exp_rs1;
   logic [31:0] exp_rs2;
   logic [31:0] exp_csr;
   logic [31:0] exp_csr_pc;
   logic [31:0] obs_rs1;
   logic [31:0] obs_rs2;
   logic [31:0] obs_csr;
   logic [31:0] obs_csr_pc;
   logic [31:0] seed = 32'h416b6c29;
   logic [4:0]  wr_regs [8];
   int          obs_cnt;
   int          check_errors;
   int          timeout_errors;
   int          n_requests;
   int          n_compared;
   string       test_name;
   event        run_end;

   serial_rf_top #(
      .WITH_CSR (1)
   ) serial_rf_top_inst (
      .i_clk          (clk),
      .i_rst_n        (rst_n),
      .i_req          (req),
      .o_ack          (ack),
      .i_trap         (trap),
      .i_mret         (mret),
      .i_mepc         (mepc),
      .i_mem_misalign (mem_misalign),
      .i_bufreg_q     (bufreg_q),
      .i_bad_pc       (bad_pc),
      .o_csr_pc       (csr_pc),
      .i_csr_en       (csr_en),
      .i_csr_addr     (csr_addr),
      .i_csr          (csr),
      .o_csr          (csr_out),
      .i_rd_wen       (rd_wen),
      .i_rd_waddr     (rd_waddr),
      .i_ctrl_rd      (ctrl_rd),
      .i_alu_rd       (alu_rd),
      .i_rd_alu_en    (rd_alu_en),
      .i_csr_rd       (csr_rd),
      .i_rd_csr_en    (rd_csr_en),
      .i_mem_rd       (mem_rd),
      .i_rs1_raddr    (rs1_raddr),
      .o_rs1          (rs1),
      .i_rs2_raddr    (rs2_raddr),
      .o_rs2          (rs2)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // Random integer register x1..x31
   function automatic logic [4:0] pick_reg();
      return 5'((lcg_next() >> 16) % 31 + 1);
   endfunction

   // Expected stream values from the model, then the model update
   function automatic void predict();
      logic [31:0] port1;
      exp_rs1 = model_x[rs1_raddr];
      if (trap) begin
         port1 = model_csr[`CSR_MTVEC];
      end else if (mret) begin
         port1 = model_csr[`CSR_MEPC];
      end else if (csr_en) begin
         port1 = model_csr[csr_addr];
      end else begin
         port1 = model_x[rs2_raddr];
      end
      exp_rs2    = port1;
      exp_csr    = csr_en ? port1 : '0;
      exp_csr_pc = port1;
      if (trap) begin
         model_csr[`CSR_MTVAL] = mem_misalign ? v_bufreg : v_bad_pc;
         model_csr[`CSR_MEPC]  = v_mepc;
      end else begin
         if (rd_wen && rd_waddr != 5'd0) begin
            model_x[rd_waddr] = v_ctrl | (v_alu & {32{rd_alu_en}}) |
                                (v_csr_rd & {32{rd_csr_en}}) | v_mem;
         end
         if (csr_en) begin
            model_csr[csr_addr] = v_csr;
         end
      end
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
      check_errors++;
   endtask

   task automatic stop_on_timeout(input string what);
      $display("Timeout in %s: %s", test_name, what);
      timeout_errors++;
      -> run_end;
      forever @(posedge clk);
   endtask

   // Idle request fields and fresh random bit streams
   task automatic next_request();
      trap         <= 1'b0;
      mret         <= 1'b0;
      mem_misalign <= 1'b0;
      csr_en       <= 1'b0;
      csr_addr     <= 2'd0;
      rd_wen       <= 1'b0;
      rd_waddr     <= 5'd0;
      rd_alu_en    <= 1'b0;
      rd_csr_en    <= 1'b0;
      rs1_raddr    <= 5'd0;
      rs2_raddr    <= 5'd0;
      v_ctrl   = lcg_next();
      v_alu    = lcg_next();
      v_csr_rd = lcg_next();
      v_mem    = lcg_next();
      v_csr    = lcg_next();
      v_mepc   = lcg_next();
      v_bufreg = lcg_next();
      v_bad_pc = lcg_next();
   endtask

   task automatic drive_bit(input int b);
      ctrl_rd  <= v_ctrl[b];
      alu_rd   <= v_alu[b];
      csr_rd   <= v_csr_rd[b];
      mem_rd   <= v_mem[b];
      csr      <= v_csr[b];
      mepc     <= v_mepc[b];
      bufreg_q <= v_bufreg[b];
      bad_pc   <= v_bad_pc[b];
   endtask

   // Edge e after ack rises samples bit e
   // A second req goes up at edge again_e
   task automatic run_request(input string name, input int drop_e, input int again_e);
      int n;
      int e;
      int last_drop;
      int low_e;
      @(posedge clk);
      test_name = name;
      predict();
      n_requests++;
      drive_bit(0);
      req <= 1'b1;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!ack && n < ACK_TIMEOUT);
      if (!ack) begin
         stop_on_timeout("o_ack did not rise");
      end
      if (n != 3) begin
         report_mismatch("ack latency", 2, n - 1);
      end
      last_drop = (again_e >= 0) ? again_e + 4 : drop_e;
      // Two drain cycles after bit 31, or one cycle after a late drop
      low_e = (last_drop + 2 > 34) ? last_drop + 2 : 34;
      e = 0;
      while (ack && e < STREAM_TIMEOUT) begin
         if (e < `RF_XLEN - 1) begin
            drive_bit(e + 1);
         end
         if (e == drop_e || e == last_drop) begin
            req <= 1'b0;
         end
         if (e == again_e) begin
            req <= 1'b1;
         end
         @(posedge clk);
         e++;
      end
      if (ack) begin
         stop_on_timeout("o_ack did not fall");
      end
      if (e != low_e) begin
         report_mismatch("ack release", low_e, e);
      end
      for (n = 0; n < 4; n++) begin
         @(posedge clk);
         if (ack) begin
            report_mismatch("ack while idle", 0, 1);
         end
      end
   endtask

   // Collects the 32 bits after ack rises and checks them
   always @(posedge clk) begin
      if (!ack) begin
         obs_cnt = 0;
      end else if (obs_cnt < `RF_XLEN) begin
         obs_rs1[obs_cnt]    = rs1;
         obs_rs2[obs_cnt]    = rs2;
         obs_csr[obs_cnt]    = csr_out;
         obs_csr_pc[obs_cnt] = csr_pc;
         obs_cnt = obs_cnt + 1;
         if (obs_cnt == `RF_XLEN) begin
            n_compared++;
            if (obs_rs1 !== exp_rs1) begin
               report_mismatch("o_rs1", exp_rs1, obs_rs1);
            end
            if (obs_rs2 !== exp_rs2) begin
               report_mismatch("o_rs2", exp_rs2, obs_rs2);
            end
            if (obs_csr !== exp_csr) begin
               report_mismatch("o_csr", exp_csr, obs_csr);
            end
            if (obs_csr_pc !== exp_csr_pc) begin
               report_mismatch("o_csr_pc", exp_csr_pc, obs_csr_pc);
            end
         end
      end
   end

   initial begin
      @(run_end);
      $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
      if (check_errors == 0 && timeout_errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   initial begin
      int i;
      for (i = 0; i < 32; i++) begin
         model_x[i] = '0;
      end
      for (i = 0; i < 4; i++) begin
         model_csr[i] = '0;
      end
      rst_n <= 1'b0;
      req   <= 1'b0;
      next_request();
      drive_bit(0);
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      // ALU results into random registers while each request reads the previous one
      for (i = 0; i < 8; i++) begin
         next_request();
         wr_regs[i] = pick_reg();
         v_ctrl = '0;
         v_mem  = '0;
         rd_wen    <= 1'b1;
         rd_waddr  <= wr_regs[i];
         rd_alu_en <= 1'b1;
         rs1_raddr <= (i > 0) ? wr_regs[i - 1] : 5'd0;
         rs2_raddr <= pick_reg();
         run_request("alu_write", 31, -1);
      end
      for (i = 0; i < 8; i++) begin
         next_request();
         rs1_raddr <= wr_regs[i];
         rs2_raddr <= wr_regs[7 - i];
         run_request("alu_readback", 31, -1);
      end

      // x0 stays zero and the ALU bits are gated off while control and memory bits pass
      next_request();
      rd_wen    <= 1'b1;
      rd_alu_en <= 1'b1;
      run_request("x0_write", 31, -1);
      next_request();
      run_request("x0_read", 31, -1);
      next_request();
      rd_wen    <= 1'b1;
      rd_waddr  <= wr_regs[0];
      rd_csr_en <= 1'b1;
      run_request("rd_gating", 31, -1);
      next_request();
      rs1_raddr <= wr_regs[0];
      run_request("rd_gating_read", 31, -1);

      // CSR writes and read back, then o_csr low without the enable
      for (i = 0; i < 8; i++) begin
         next_request();
         csr_en   <= 1'b1;
         csr_addr <= (i < 4) ? 2'(i) : 2'(7 - i);
         if (i < 4) begin
            run_request("csr_write", 31, -1);
         end else begin
            run_request("csr_read", 31, -1);
         end
      end
      next_request();
      rs2_raddr <= wr_regs[1];
      run_request("csr_gated", 31, -1);

      // Traps with and without a misaligned access, then mret
      for (i = 0; i < 2; i++) begin
         next_request();
         trap         <= 1'b1;
         mem_misalign <= i[0];
         rd_wen       <= 1'b1;
         rd_waddr     <= wr_regs[2];
         run_request("trap", 31, -1);
         // The rd of the trapping request keeps its old value
         next_request();
         csr_en    <= 1'b1;
         csr_addr  <= `CSR_MTVAL;
         rs1_raddr <= wr_regs[2];
         run_request("mtval_read", 31, -1);
      end
      next_request();
      mret <= 1'b1;
      run_request("mret", 31, -1);

      // Handshake ordering and a second req while ack is high
      next_request();
      run_request("early_drop", 0, -1);
      next_request();
      run_request("late_drop", 40, -1);
      next_request();
      rd_wen    <= 1'b1;
      rd_waddr  <= wr_regs[3];
      rd_alu_en <= 1'b1;
      run_request("req_in_stream", 0, 10);
      next_request();
      rd_wen    <= 1'b1;
      rd_waddr  <= wr_regs[4];
      rd_alu_en <= 1'b1;
      run_request("req_in_drain", 31, 32);
      next_request();
      rs1_raddr <= wr_regs[3];
      rs2_raddr <= wr_regs[4];
      run_request("after_second_req", 31, -1);

      @(posedge clk);
      if (n_compared != n_requests) begin
         report_mismatch("compared requests", n_requests, n_compared);
      end
      -> run_end;
   end

endmodule

`default_nettype wire

// File: logic/serial_rf_top.sv
`timescale 1ns/10ps
`include "serial_rf_config.svh"
`default_nettype none

module serial_rf_top #(
   parameter WITH_CSR = 1
) (
   input  wire                          i_clk,
   input  wire                          i_rst_n,
   // Handshake
   input  wire                          i_req,
   output logic                         o_ack,
   // Trap
   input  wire                          i_trap,
   input  wire                          i_mret,
   input  wire                          i_mepc,
   input  wire                          i_mem_misalign,
   input  wire                          i_bufreg_q,
   input  wire                          i_bad_pc,
   output logic                         o_csr_pc,
   // CSR
   input  wire                          i_csr_en,
   input  wire serial_rf_pkg::csr_sel_t i_csr_addr,
   input  wire                          i_csr,
   output logic                         o_csr,
   // rd write
   input  wire                          i_rd_wen,
   input  wire [4:0]                    i_rd_waddr,
   input  wire                          i_ctrl_rd,
   input  wire                          i_alu_rd,
   input  wire                          i_rd_alu_en,
   input  wire                          i_csr_rd,
   input  wire                          i_rd_csr_en,
   input  wire                          i_mem_rd,
   // Source operands
   input  wire [4:0]                    i_rs1_raddr,
   output logic                         o_rs1,
   input  wire [4:0]                    i_rs2_raddr,
   output logic                         o_rs2
);
   import serial_rf_pkg::*;

   localparam int RAM_AW = $bits(rf_addr_t) + $clog2(`RF_WORDS_PER_REG);

   rf_addr_t              wreg0;
   rf_addr_t              wreg1;
   rf_addr_t              rreg0;
   rf_addr_t              rreg1;
   logic                  wen0;
   logic                  wen1;
   logic                  wdata0;
   logic                  wdata1;
   logic                  rdata0;
   logic                  rdata1;
   logic [RAM_AW-1:0]     ram_raddr;
   logic [RAM_AW-1:0]     ram_waddr;
   logic [`RF_WORD_W-1:0] ram_rdata;
   logic [`RF_WORD_W-1:0] ram_wdata;
   logic                  ram_wen;

   rf_port_map #(
      .WITH_CSR (WITH_CSR)
   ) rf_port_map_inst (
      .i_trap         (i_trap),
      .i_mret         (i_mret),
      .i_mepc         (i_mepc),
      .i_mem_misalign (i_mem_misalign),
      .i_bufreg_q     (i_bufreg_q),
      .i_bad_pc       (i_bad_pc),
      .i_csr_en       (i_csr_en),
      .i_csr_addr     (i_csr_addr),
      .i_csr          (i_csr),
      .i_rd_wen       (i_rd_wen),
      .i_rd_waddr     (i_rd_waddr),
      .i_ctrl_rd      (i_ctrl_rd),
      .i_alu_rd       (i_alu_rd),
      .i_rd_alu_en    (i_rd_alu_en),
      .i_csr_rd       (i_csr_rd),
      .i_rd_csr_en    (i_rd_csr_en),
      .i_mem_rd       (i_mem_rd),
      .i_rs1_raddr    (i_rs1_raddr),
      .i_rs2_raddr    (i_rs2_raddr),
      .i_rdata0       (rdata0),
      .i_rdata1       (rdata1),
      .o_wreg0        (wreg0),
      .o_wreg1        (wreg1),
      .o_rreg0        (rreg0),
      .o_rreg1        (rreg1),
      .o_wen0         (wen0),
      .o_wen1         (wen1),
      .o_wdata0       (wdata0),
      .o_wdata1       (wdata1),
      .o_csr          (o_csr),
      .o_csr_pc       (o_csr_pc),
      .o_rs1          (o_rs1),
      .o_rs2          (o_rs2)
   );

   rf_serializer rf_serializer_inst (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_req       (i_req),
      .o_ack       (o_ack),
      .i_wreg0     (wreg0),
      .i_wreg1     (wreg1),
      .i_rreg0     (rreg0),
      .i_rreg1     (rreg1),
      .i_wen0      (wen0),
      .i_wen1      (wen1),
      .i_wdata0    (wdata0),
      .i_wdata1    (wdata1),
      .o_rdata0    (rdata0),
      .o_rdata1    (rdata1),
      .i_ram_rdata (ram_rdata),
      .o_ram_raddr (ram_raddr),
      .o_ram_waddr (ram_waddr),
      .o_ram_wdata (ram_wdata),
      .o_ram_wen   (ram_wen)
   );

   rf_ram rf_ram_inst (
      .i_clk   (i_clk),
      .i_raddr (ram_raddr),
      .i_waddr (ram_waddr),
      .i_wdata (ram_wdata),
      .i_wen   (ram_wen),
      .o_rdata (ram_rdata)
   );

endmodule

`default_nettype wire

// File: logic/rf_ram.sv
`timescale 1ns/10ps
`include "serial_rf_config.svh"
`default_nettype none

module rf_ram (
   input  wire                   i_clk,
   input  wire [$bits(serial_rf_pkg::rf_addr_t)+$clog2(`RF_WORDS_PER_REG)-1:0] i_raddr,
   input  wire [$bits(serial_rf_pkg::rf_addr_t)+$clog2(`RF_WORDS_PER_REG)-1:0] i_waddr,
   input  wire [`RF_WORD_W-1:0]  i_wdata,
   input  wire                   i_wen,
   output logic [`RF_WORD_W-1:0] o_rdata
);
   import serial_rf_pkg::*;

   localparam int IDX_W  = $clog2(`RF_WORDS_PER_REG);
   // 32 integer registers and 4 machine CSRs
   localparam int N_REGS = 36;
   localparam int DEPTH  = N_REGS * `RF_WORDS_PER_REG;

   logic [`RF_WORD_W-1:0] mem [DEPTH];
   rf_addr_t              wreg;

   // Start from zero so x0 and untouched registers read zero
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   always @(posedge i_clk) begin
      if (i_wen) begin
         mem[i_waddr] <= i_wdata;
      end
      o_rdata <= mem[i_raddr];
   end

   assign wreg = i_waddr[$bits(i_waddr)-1:IDX_W];

   // Only x1..x31 and the four CSR slots are ever written
   legal_waddr: assert property (@(posedge i_clk)
      i_wen |-> (wreg != '0) && (!wreg[5] || wreg[4:2] == '0))
      else $error("rf_ram: write to x0 or unused CSR slot %0d", wreg);

endmodule

`default_nettype wire

// File: logic/rf_serializer.sv
`timescale 1ns/10ps
`include "serial_rf_config.svh"
`default_nettype none

module rf_serializer (
   input  wire                          i_clk,
   input  wire                          i_rst_n,
   // Four-phase handshake
   input  wire                          i_req,
   output logic                         o_ack,
   // Port mapper side
   input  wire serial_rf_pkg::rf_addr_t i_wreg0,
   input  wire serial_rf_pkg::rf_addr_t i_wreg1,
   input  wire serial_rf_pkg::rf_addr_t i_rreg0,
   input  wire serial_rf_pkg::rf_addr_t i_rreg1,
   input  wire                          i_wen0,
   input  wire                          i_wen1,
   input  wire                          i_wdata0,
   input  wire                          i_wdata1,
   output logic                         o_rdata0,
   output logic                         o_rdata1,
   // RAM side
   input  wire [`RF_WORD_W-1:0]         i_ram_rdata,
   output logic [$bits(serial_rf_pkg::rf_addr_t)+$clog2(`RF_WORDS_PER_REG)-1:0] o_ram_raddr,
   output logic [$bits(serial_rf_pkg::rf_addr_t)+$clog2(`RF_WORDS_PER_REG)-1:0] o_ram_waddr,
   output logic [`RF_WORD_W-1:0]        o_ram_wdata,
   output logic                         o_ram_wen
);
   import serial_rf_pkg::*;

   localparam int IDX_W = $clog2(`RF_WORDS_PER_REG);
   localparam int CNT_W = $clog2(`RF_XLEN);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_PREFETCH,
      ST_STREAM,
      ST_DRAIN,
      ST_HOLD
   } state_t;

   state_t                state;
   logic [CNT_W-1:0]      bit_cnt;
   logic                  streaming;
   logic                  odd_bit;
   // Addresses latched at request time
   rf_addr_t              rreg0_q;
   rf_addr_t              rreg1_q;
   rf_addr_t              wreg0_q;
   rf_addr_t              wreg1_q;
   // Read side
   logic                  rsel1;
   logic [IDX_W-1:0]      ridx;
   logic [`RF_WORD_W-1:0] rbuf0;
   logic                  rhold1;
   // Write side
   logic                  wlo0;
   logic                  wlo1;
   logic [`RF_WORD_W-1:0] wword0;
   logic [`RF_WORD_W-1:0] wword1;
   logic                  wen0_q;
   logic                  wen1_q;
   logic [IDX_W-1:0]      widx;
   logic                  wpend0;
   logic                  wpend1;

   assign streaming = (state == ST_STREAM);
   assign odd_bit   = bit_cnt[0];

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state   <= ST_IDLE;
         o_ack   <= 1'b0;
         bit_cnt <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (i_req) begin
                  state <= ST_PREFETCH;
               end
            end
            ST_PREFETCH: begin
               state <= ST_STREAM;
               o_ack <= 1'b1;
            end
            ST_STREAM: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == CNT_W'(`RF_XLEN - 1)) begin
                  state <= ST_DRAIN;
               end
            end
            ST_DRAIN: begin
               // Two cycles for the last port-0 and port-1 words
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt[0]) begin
                  bit_cnt <= '0;
                  state   <= i_req ? ST_HOLD : ST_IDLE;
                  o_ack   <= i_req;
               end
            end
            ST_HOLD: begin
               if (!i_req) begin
                  state <= ST_IDLE;
                  o_ack <= 1'b0;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Read words alternate, port 0 on even bits and port 1 on odd bits,
   // always one word ahead of the bits being streamed
   assign rsel1 = (state == ST_PREFETCH) || (streaming && odd_bit);
   assign ridx  = streaming ? bit_cnt[CNT_W-1:1] + IDX_W'(1) : '0;

   always_comb begin
      if (rsel1) begin
         o_ram_raddr = {rreg1_q, ridx};
      end else if (state == ST_IDLE) begin
         o_ram_raddr = {i_rreg0, ridx};
      end else begin
         o_ram_raddr = {rreg0_q, ridx};
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == ST_IDLE && i_req) begin
         rreg0_q <= i_rreg0;
         rreg1_q <= i_rreg1;
         wreg0_q <= i_wreg0;
         wreg1_q <= i_wreg1;
      end
      // Port-0 word lands one cycle early, shift out one bit per cycle
      if (state == ST_PREFETCH || (streaming && odd_bit)) begin
         rbuf0 <= i_ram_rdata;
      end else if (streaming) begin
         rbuf0 <= rbuf0 >> 1;
      end
      if (streaming && !odd_bit) begin
         rhold1 <= i_ram_rdata[1];
         wlo0   <= i_wdata0;
         wlo1   <= i_wdata1;
      end
      if (streaming && odd_bit) begin
         wword0 <= {i_wdata0, wlo0};
         wword1 <= {i_wdata1, wlo1};
         wen0_q <= i_wen0;
         wen1_q <= i_wen1;
         widx   <= bit_cnt[CNT_W-1:1];
      end
   end

   // Port-1 word arrives just in time for its even bit
   assign o_rdata0 = rbuf0[0];
   assign o_rdata1 = odd_bit ? rhold1 : i_ram_rdata[0];

   // Port 0 writes after each odd bit, port 1 the cycle after
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wpend0 <= 1'b0;
         wpend1 <= 1'b0;
      end else begin
         wpend0 <= streaming && odd_bit;
         wpend1 <= wpend0;
      end
   end

   assign o_ram_wen   = (wpend0 & wen0_q) | (wpend1 & wen1_q);
   assign o_ram_waddr = wpend0 ? {wreg0_q, widx} : {wreg1_q, widx};
   assign o_ram_wdata = wpend0 ? wword0 : wword1;

   wen_in_window: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_ram_wen |-> (state == ST_STREAM || state == ST_DRAIN))
      else $error("rf_serializer: RAM write outside stream/drain");

   cnt_frozen_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !o_ack |=> $stable(bit_cnt))
      else $error("rf_serializer: bit counter moved without ack");

endmodule

`default_nettype wire

// File: logic/rf_port_map.sv
`timescale 1ns/10ps
`include "serial_rf_config.svh"
`default_nettype none

module rf_port_map #(
   parameter WITH_CSR = 1
) (
   // Trap side
   input  wire                          i_trap,
   input  wire                          i_mret,
   input  wire                          i_mepc,
   input  wire                          i_mem_misalign,
   input  wire                          i_bufreg_q,
   input  wire                          i_bad_pc,
   // CSR side
   input  wire                          i_csr_en,
   input  wire serial_rf_pkg::csr_sel_t i_csr_addr,
   input  wire                          i_csr,
   // rd write sources
   input  wire                          i_rd_wen,
   input  wire [4:0]                    i_rd_waddr,
   input  wire                          i_ctrl_rd,
   input  wire                          i_alu_rd,
   input  wire                          i_rd_alu_en,
   input  wire                          i_csr_rd,
   input  wire                          i_rd_csr_en,
   input  wire                          i_mem_rd,
   // Source registers
   input  wire [4:0]                    i_rs1_raddr,
   input  wire [4:0]                    i_rs2_raddr,
   // Bits coming back from the serializer
   input  wire                          i_rdata0,
   input  wire                          i_rdata1,
   // Register file ports
   output serial_rf_pkg::rf_addr_t      o_wreg0,
   output serial_rf_pkg::rf_addr_t      o_wreg1,
   output serial_rf_pkg::rf_addr_t      o_rreg0,
   output serial_rf_pkg::rf_addr_t      o_rreg1,
   output logic                         o_wen0,
   output logic                         o_wen1,
   output logic                         o_wdata0,
   output logic                         o_wdata1,
   // Core side read bits
   output logic                         o_csr,
   output logic                         o_csr_pc,
   output logic                         o_rs1,
   output logic                         o_rs2
);
   import serial_rf_pkg::*;

   logic rd_wen;

   function automatic rf_addr_t csr_reg(input csr_sel_t sel);
      return {4'b1000, sel};
   endfunction

   // Never write x0, so it keeps reading zero
   assign rd_wen = i_rd_wen & (|i_rd_waddr);

   // Port 0 always reads rs1
   assign o_rreg0 = {1'b0, i_rs1_raddr};
   assign o_rs1   = i_rdata0;
   assign o_rs2   = i_rdata1;

   generate
      if (WITH_CSR) begin : g_csr
         logic rd_bit;
         logic mtval_bit;

         assign rd_bit = i_ctrl_rd |
                         (i_alu_rd & i_rd_alu_en) |
                         (i_csr_rd & i_rd_csr_en) |
                         i_mem_rd;

         // Faulting address on a misaligned access, else the bad PC
         assign mtval_bit = i_mem_misalign ? i_bufreg_q : i_bad_pc;

         // Port 0 carries rd, or mtval on a trap
         assign o_wreg0  = i_trap ? csr_reg(`CSR_MTVAL) : {1'b0, i_rd_waddr};
         assign o_wdata0 = i_trap ? mtval_bit : rd_bit;
         assign o_wen0   = i_trap | rd_wen;

         // Port 1 carries the CSR write, or mepc on a trap
         assign o_wreg1  = i_trap ? csr_reg(`CSR_MEPC) : csr_reg(i_csr_addr);
         assign o_wdata1 = i_trap ? i_mepc : i_csr;
         assign o_wen1   = i_trap | i_csr_en;

         // Trap vector first, then return address, then CSR, then rs2
         always_comb begin
            if (i_trap) begin
               o_rreg1 = csr_reg(`CSR_MTVEC);
            end else if (i_mret) begin
               o_rreg1 = csr_reg(`CSR_MEPC);
            end else if (i_csr_en) begin
               o_rreg1 = csr_reg(i_csr_addr);
            end else begin
               o_rreg1 = {1'b0, i_rs2_raddr};
            end
         end

         assign o_csr    = i_rdata1 & i_csr_en;
         assign o_csr_pc = i_rdata1;
      end else begin : g_no_csr
         logic rd_bit;

         assign rd_bit = i_ctrl_rd | (i_alu_rd & i_rd_alu_en) | i_mem_rd;

         assign o_wreg0  = {1'b0, i_rd_waddr};
         assign o_wdata0 = rd_bit;
         assign o_wen0   = rd_wen;

         // Second write port unused without CSRs
         assign o_wreg1  = '0;
         assign o_wdata1 = 1'b0;
         assign o_wen1   = 1'b0;

         assign o_rreg1  = {1'b0, i_rs2_raddr};
         assign o_csr    = 1'b0;
         assign o_csr_pc = 1'b0;
      end
   endgenerate

   // A trap and a return from trap exclude each other
   trap_mret_excl: assert final ((i_trap & i_mret) !== 1'b1)
      else $error("rf_port_map: i_trap and i_mret high together");

endmodule

`default_nettype wire

// File: logic/serial_rf_pkg.sv
`default_nettype none

package serial_rf_pkg;

   // Register file address
   // Bit 5 selects the CSR space
   // Low bits hold the integer register number or the CSR index
   //   0xxxxx  integer register x0..x31
   //   1000xx  mscratch, mtvec, mepc, mtval
   typedef logic [5:0] rf_addr_t;

   // Index of one of the four machine CSRs
   typedef logic [1:0] csr_sel_t;

endpackage

`default_nettype wire

// File: include/serial_rf_config.svh
`ifndef SERIAL_RF_CONFIG_SVH
`define SERIAL_RF_CONFIG_SVH

`default_nettype none

// Operand width, one bit moves per clock
`define RF_XLEN 32

// RAM word width and the RAM words that hold one register
`define RF_WORD_W 2
`define RF_WORDS_PER_REG 16

// Machine CSR slots at the top of the register space
// Register address of a CSR is {4'b1000, index}
`define CSR_MSCRATCH 2'd0
`define CSR_MTVEC 2'd1
`define CSR_MEPC 2'd2
`define CSR_MTVAL 2'd3

`default_nettype wire

`endif
